// ==== source/isa_pkg.sv ====
// RV64 integer adder ISA definitions
// opcode one-hot layout, data width and register index types
package isa_pkg;

	localparam int xlen = 64;

	typedef logic [4:0] reg_idx_t;
	typedef logic [xlen-1:0] xdata_t;

	// one-hot, lui in the top bit
	typedef logic [7:0] adder_op_t;

	localparam int OP_LUI   = 7;
	localparam int OP_AUIPC = 6;
	localparam int OP_ADDI  = 5;
	localparam int OP_ADDIW = 4;
	localparam int OP_ADD   = 3;
	localparam int OP_ADDW  = 2;
	localparam int OP_SUB   = 1;
	localparam int OP_SUBW  = 0;

	function automatic logic op_uses_rs1(input adder_op_t op);
		return ~(op[OP_LUI] | op[OP_AUIPC]);
	endfunction

	// register-register forms only
	function automatic logic op_uses_rs2(input adder_op_t op);
		return op[OP_ADD] | op[OP_ADDW] | op[OP_SUB] | op[OP_SUBW];
	endfunction

	function automatic logic op_is32(input adder_op_t op);
		return op[OP_ADDIW] | op[OP_ADDW] | op[OP_SUBW];
	endfunction

endpackage

// ==== source/issue_pkg.sv ====
// adder issue path structures
// buffer entry layout and execute parameters passed from issue to execute
package issue_pkg;

	import isa_pkg::*;

	// one dispatched instruction as held in the buffer
	typedef struct packed {
		adder_op_t op;
		xdata_t    pc;
		xdata_t    imm;
		reg_idx_t  rd;
		reg_idx_t  rs1;
		reg_idx_t  rs2;
	} issue_entry_t;

	// operands already resolved, ready for the adder
	typedef struct packed {
		logic     fun_add;
		logic     fun_sub;
		logic     is32;
		reg_idx_t rd;
		xdata_t   op1;
		xdata_t   op2;
	} exe_param_t;

endpackage

// ==== source/adder_buffer.sv ====
// adder issue buffer
// DP entries with malloc flags, fills the lowest free entry, frees on pop
`timescale 1ns/1ns

module adder_buffer import isa_pkg::*, issue_pkg::*; #(
	parameter int DP = 4
) (
	input  logic                   CLK,
	input  logic                   rst_n,
	input  logic                   flush,
	input  logic                   dispatch_valid,
	input  adder_op_t              dispatch_op,
	input  xdata_t                 dispatch_pc,
	input  xdata_t                 dispatch_imm,
	input  reg_idx_t               dispatch_rd,
	input  reg_idx_t               dispatch_rs1,
	input  reg_idx_t               dispatch_rs2,
	input  logic                   pop,
	input  logic [$clog2(DP)-1:0]  pop_index,
	output logic [DP-1:0]          entry_valid,
	output issue_entry_t           entries [DP],
	output logic                   dispatch_full
);

	localparam int IW = $clog2(DP);

	logic          free_found;
	logic [IW-1:0] alloc_index;
	logic          dispatch_accept;

	// lowest free entry
	always_comb begin
		free_found = 1'b0;
		alloc_index = '0;
		for (int i = 0; i < DP; i++) begin
			if (!entry_valid[i] && !free_found) begin
				free_found = 1'b1;
				alloc_index = IW'(i);
			end
		end
	end

	assign dispatch_full = &entry_valid;
	assign dispatch_accept = dispatch_valid & free_found;

	// alloc and pop never hit the same entry
	always_ff @(posedge CLK) begin
		if (!rst_n || flush) begin
			entry_valid <= '0;
		end else begin
			if (pop) begin
				entry_valid[pop_index] <= 1'b0;
			end
			if (dispatch_accept) begin
				entry_valid[alloc_index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (dispatch_accept) begin
			entries[alloc_index].op <= dispatch_op;
			entries[alloc_index].pc <= dispatch_pc;
			entries[alloc_index].imm <= dispatch_imm;
			entries[alloc_index].rd <= dispatch_rd;
			entries[alloc_index].rs1 <= dispatch_rs1;
			entries[alloc_index].rs2 <= dispatch_rs2;
		end
	end

endmodule

// ==== source/adder_slot.sv ====
// adder readiness slot
// checks RAW clearance of one buffer entry and resolves its operands
`timescale 1ns/1ns

module adder_slot import isa_pkg::*, issue_pkg::*; (
	input  logic         entry_valid,
	input  issue_entry_t entry,
	input  logic [31:0]  reg_ready,
	input  xdata_t       reg_data [32],
	output logic         clear_raw,
	output exe_param_t   slot_param
);

	logic   rs1_ready;
	logic   rs2_ready;
	logic   imm_form;
	xdata_t src1;
	xdata_t src2;

	// x0 never waits
	assign rs1_ready = reg_ready[entry.rs1] | (entry.rs1 == 5'd0);
	assign rs2_ready = reg_ready[entry.rs2] | (entry.rs2 == 5'd0);

	assign clear_raw = entry_valid
		& (~op_uses_rs1(entry.op) | rs1_ready)
		& (~op_uses_rs2(entry.op) | rs2_ready);

	assign src1 = reg_data[entry.rs1];
	assign src2 = reg_data[entry.rs2];

	assign imm_form = entry.op[OP_LUI] | entry.op[OP_AUIPC]
		| entry.op[OP_ADDI] | entry.op[OP_ADDIW];

	always_comb begin
		if (entry.op[OP_LUI]) begin
			slot_param.op1 = '0;
		end else if (entry.op[OP_AUIPC]) begin
			slot_param.op1 = entry.pc;
		end else begin
			slot_param.op1 = src1;
		end
	end

	assign slot_param.op2 = imm_form ? entry.imm : src2;

	assign slot_param.fun_add = entry.op[OP_LUI] | entry.op[OP_AUIPC]
		| entry.op[OP_ADDI] | entry.op[OP_ADDIW]
		| entry.op[OP_ADD] | entry.op[OP_ADDW];
	assign slot_param.fun_sub = entry.op[OP_SUB] | entry.op[OP_SUBW];
	assign slot_param.is32 = op_is32(entry.op);
	assign slot_param.rd = entry.rd;

endmodule

// ==== source/adder_issue.sv ====
// adder issue select
// picks the lowest RAW-clear entry and registers its execute parameters
`timescale 1ns/1ns

module adder_issue import issue_pkg::*; #(
	parameter int DP = 4
) (
	input  logic                   CLK,
	input  logic                   rst_n,
	input  logic                   flush,
	input  logic [DP-1:0]          clear_raw,
	input  exe_param_t             slot_param [DP],
	output logic                   pop,
	output logic [$clog2(DP)-1:0]  pop_index,
	output logic                   exe_valid,
	output exe_param_t             exe_param
);

	localparam int IW = $clog2(DP);

	logic          any_ready;
	logic [IW-1:0] sel_index;

	// first set bit wins
	always_comb begin
		any_ready = 1'b0;
		sel_index = '0;
		for (int i = 0; i < DP; i++) begin
			if (clear_raw[i] && !any_ready) begin
				any_ready = 1'b1;
				sel_index = IW'(i);
			end
		end
	end

	// adder always takes a new op, so pop is the next exe_valid
	assign pop = any_ready & ~flush;
	assign pop_index = sel_index;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			exe_valid <= 1'b0;
		end else begin
			exe_valid <= pop;
		end
	end

	// holds last value when nothing issues
	always_ff @(posedge CLK) begin
		if (pop) begin
			exe_param <= slot_param[sel_index];
		end
	end

endmodule

// ==== source/adder_exec.sv ====
// adder execute stage
// add or subtract, sign extension of 32-bit forms, registered write-back
`timescale 1ns/1ns

module adder_exec import isa_pkg::*, issue_pkg::*; (
	input  logic       CLK,
	input  logic       rst_n,
	input  logic       exe_valid,
	input  exe_param_t exe_param,
	output logic       wb_valid,
	output reg_idx_t   wb_rd,
	output xdata_t     wb_data
);

	xdata_t raw_result;
	xdata_t result;

	always_comb begin
		unique case ({exe_param.fun_add, exe_param.fun_sub})
			2'b10: raw_result = exe_param.op1 + exe_param.op2;
			2'b01: raw_result = exe_param.op1 - exe_param.op2;
			default: raw_result = '0;
		endcase
	end

	// W forms keep the low word, extended from bit 31
	assign result = exe_param.is32 ? {{32{raw_result[31]}}, raw_result[31:0]} : raw_result;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= exe_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (exe_valid) begin
			wb_rd <= exe_param.rd;
			wb_data <= result;
		end
	end

endmodule

// ==== source/regfile_wb.sv ====
// integer register file with write-back log
// 32x64 registers, ready bit cleared on dispatch and set on write-back
`timescale 1ns/1ns

module regfile_wb import isa_pkg::*; (
	input  logic        CLK,
	input  logic        rst_n,
	input  logic        dispatch_valid,
	input  reg_idx_t    dispatch_rd,
	input  logic        wb_valid,
	input  reg_idx_t    wb_rd,
	input  xdata_t      wb_data,
	output logic [31:0] reg_ready,
	output xdata_t      reg_data [32]
);

	xdata_t      regs [32];
	logic [31:0] wb_log;

	// x0 is never written, so it reads zero
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_valid && wb_rd != 5'd0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// dispatch comes later in program order than any pending write-back
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wb_log <= '1;
		end else begin
			if (wb_valid) begin
				wb_log[wb_rd] <= 1'b1;
			end
			if (dispatch_valid && dispatch_rd != 5'd0) begin
				wb_log[dispatch_rd] <= 1'b0;
			end
		end
	end

	assign reg_ready = wb_log;
	assign reg_data = regs;

endmodule

// ==== source/adder_core.sv ====
// integer adder issue path top level
// buffer, readiness slots, issue select, execute and register file
`timescale 1ns/1ns

module adder_core import isa_pkg::*, issue_pkg::*; #(
	parameter int DP = 4
) (
	input  logic      CLK,
	input  logic      rst_n,
	input  logic      flush,
	input  logic      dispatch_valid,
	input  adder_op_t dispatch_op,
	input  xdata_t    dispatch_pc,
	input  xdata_t    dispatch_imm,
	input  reg_idx_t  dispatch_rd,
	input  reg_idx_t  dispatch_rs1,
	input  reg_idx_t  dispatch_rs2,
	output logic      dispatch_full,
	output logic      wb_valid,
	output reg_idx_t  wb_rd,
	output xdata_t    wb_data
);

	logic                  pop;
	logic [$clog2(DP)-1:0] pop_index;
	logic [DP-1:0]         entry_valid;
	issue_entry_t          entries [DP];
	logic [DP-1:0]         clear_raw;
	exe_param_t            slot_param [DP];
	logic                  exe_valid;
	exe_param_t            exe_param;
	logic [31:0]           reg_ready;
	xdata_t                reg_data [32];

	adder_buffer #(
		.DP(DP)
	) adder_buffer_i (
		.CLK(CLK),
		.rst_n(rst_n),
		.flush(flush),
		.dispatch_valid(dispatch_valid),
		.dispatch_op(dispatch_op),
		.dispatch_pc(dispatch_pc),
		.dispatch_imm(dispatch_imm),
		.dispatch_rd(dispatch_rd),
		.dispatch_rs1(dispatch_rs1),
		.dispatch_rs2(dispatch_rs2),
		.pop(pop),
		.pop_index(pop_index),
		.entry_valid(entry_valid),
		.entries(entries),
		.dispatch_full(dispatch_full)
	);

	// one slot per buffer entry
	for (genvar i = 0; i < DP; i++) begin : g_slot
		adder_slot adder_slot_i (
			.entry_valid(entry_valid[i]),
			.entry(entries[i]),
			.reg_ready(reg_ready),
			.reg_data(reg_data),
			.clear_raw(clear_raw[i]),
			.slot_param(slot_param[i])
		);
	end

	adder_issue #(
		.DP(DP)
	) adder_issue_i (
		.CLK(CLK),
		.rst_n(rst_n),
		.flush(flush),
		.clear_raw(clear_raw),
		.slot_param(slot_param),
		.pop(pop),
		.pop_index(pop_index),
		.exe_valid(exe_valid),
		.exe_param(exe_param)
	);

	adder_exec adder_exec_i (
		.CLK(CLK),
		.rst_n(rst_n),
		.exe_valid(exe_valid),
		.exe_param(exe_param),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

	regfile_wb regfile_wb_i (
		.CLK(CLK),
		.rst_n(rst_n),
		.dispatch_valid(dispatch_valid),
		.dispatch_rd(dispatch_rd),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.reg_ready(reg_ready),
		.reg_data(reg_data)
	);

endmodule

// ==== tb/adder_core_tb.sv ====
// testbench for the integer adder issue path
// table of dispatches against a program-order reference model
`timescale 1ns/1ns

module adder_core_tb import isa_pkg::*;;

	localparam int DP = 4;
	localparam int MAX_ROWS = 40;
	localparam xdata_t BASE_PC = 64'h0000_0000_8000_0000;
	// out-of-order pair where the younger one writes back first
	localparam int OOO_WAITING_RD = 18;
	localparam int OOO_YOUNG_RD = 19;

	localparam adder_op_t lui_op = adder_op_t'(1) << OP_LUI;
	localparam adder_op_t auipc_op = adder_op_t'(1) << OP_AUIPC;
	localparam adder_op_t addi_op = adder_op_t'(1) << OP_ADDI;
	localparam adder_op_t addiw_op = adder_op_t'(1) << OP_ADDIW;
	localparam adder_op_t add_op = adder_op_t'(1) << OP_ADD;
	localparam adder_op_t addw_op = adder_op_t'(1) << OP_ADDW;
	localparam adder_op_t sub_op = adder_op_t'(1) << OP_SUB;
	localparam adder_op_t subw_op = adder_op_t'(1) << OP_SUBW;

	typedef struct packed {
		adder_op_t  op;
		reg_idx_t   rd;
		reg_idx_t   rs1;
		reg_idx_t   rs2;
		xdata_t     imm;
		logic [7:0] gap;
		logic       flush_after;
		logic       lat_check;
	} row_t;

	logic      CLK = 1'b0;
	logic      rst_n;
	logic      flush;
	logic      dispatch_valid;
	adder_op_t dispatch_op;
	xdata_t    dispatch_pc;
	xdata_t    dispatch_imm;
	reg_idx_t  dispatch_rd;
	reg_idx_t  dispatch_rs1;
	reg_idx_t  dispatch_rs2;
	logic      dispatch_full;
	logic      wb_valid;
	reg_idx_t  wb_rd;
	xdata_t    wb_data;

	row_t        rows [MAX_ROWS];
	int          n_rows = 0;
	logic [63:0] rng_state = 64'd36;
	int          cycle_count = 0;
	xdata_t      model_regs [32];
	xdata_t      expected_val [32];
	int          disp_cycle [32];
	int          wb_cycle [32];
	logic [31:0] dispatched = '0;
	logic [31:0] lat_check = '0;
	logic [31:0] written = '0;
	int          dispatch_count = 0;
	int          wb_count = 0;
	logic        saw_full = 1'b0;

	adder_core #(
		.DP(DP)
	) adder_core_i (
		.CLK(CLK),
		.rst_n(rst_n),
		.flush(flush),
		.dispatch_valid(dispatch_valid),
		.dispatch_op(dispatch_op),
		.dispatch_pc(dispatch_pc),
		.dispatch_imm(dispatch_imm),
		.dispatch_rd(dispatch_rd),
		.dispatch_rs1(dispatch_rs1),
		.dispatch_rs2(dispatch_rs2),
		.dispatch_full(dispatch_full),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

	always #50 CLK = ~CLK;

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
	end

	function automatic logic [63:0] xorshift_next(input logic [63:0] s);
		logic [63:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 7);
		x = x ^ (x << 17);
		return x;
	endfunction

	function automatic xdata_t sign_extend_word(input xdata_t v);
		return {{32{v[31]}}, v[31:0]};
	endfunction

	// result of one instruction from the ISA rules
	function automatic xdata_t model_result(input adder_op_t op, input xdata_t pc,
			input xdata_t imm, input xdata_t a, input xdata_t b);
		xdata_t r;
		r = '0;
		if (op[OP_LUI]) r = imm;
		else if (op[OP_AUIPC]) r = pc + imm;
		else if (op[OP_ADDI]) r = a + imm;
		else if (op[OP_ADDIW]) r = sign_extend_word(a + imm);
		else if (op[OP_ADD]) r = a + b;
		else if (op[OP_ADDW]) r = sign_extend_word(a + b);
		else if (op[OP_SUB]) r = a - b;
		else if (op[OP_SUBW]) r = sign_extend_word(a - b);
		return r;
	endfunction

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("TEST FAILED");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic add_row(input adder_op_t op, input int rd, input int rs1, input int rs2,
			input xdata_t imm, input int use_rnd, input int gap, input int flush_after,
			input int lat);
		xdata_t v;
		v = imm;
		if (use_rnd != 0) begin
			rng_state = xorshift_next(rng_state);
			v = rng_state;
		end
		rows[n_rows].op = op;
		rows[n_rows].rd = reg_idx_t'(rd);
		rows[n_rows].rs1 = reg_idx_t'(rs1);
		rows[n_rows].rs2 = reg_idx_t'(rs2);
		rows[n_rows].imm = v;
		rows[n_rows].gap = 8'(gap);
		rows[n_rows].flush_after = (flush_after != 0);
		rows[n_rows].lat_check = (lat != 0);
		n_rows++;
	endtask

	// op, rd, rs1, rs2, imm, random imm, gap, flush after, check latency
	task automatic build_table();
		// every op with ready sources and W forms overflowing bit 31
		add_row(lui_op, 1, 0, 0, 64'h7fff_fff0, 0, 0, 0, 1);
		add_row(lui_op, 2, 0, 0, 64'h0, 1, 0, 0, 1);
		add_row(auipc_op, 3, 0, 0, 64'h800, 0, 4, 0, 1);
		add_row(addi_op, 4, 1, 0, 64'h20, 0, 0, 0, 1);
		add_row(addiw_op, 5, 1, 0, 64'h20, 0, 0, 0, 1);
		add_row(add_op, 6, 1, 2, 64'h0, 0, 0, 0, 1);
		add_row(addw_op, 7, 1, 1, 64'h0, 0, 0, 0, 1);
		add_row(sub_op, 8, 2, 1, 64'h0, 0, 0, 0, 1);
		add_row(subw_op, 9, 2, 1, 64'h0, 0, 0, 0, 1);
		add_row(addiw_op, 10, 2, 0, 64'h0, 1, 0, 0, 1);
		add_row(subw_op, 11, 3, 2, 64'h0, 0, 6, 0, 1);
		// RAW chain whose head reads x0
		add_row(addi_op, 12, 0, 0, 64'h0, 1, 0, 0, 1);
		add_row(addiw_op, 13, 12, 0, 64'h0, 1, 0, 0, 0);
		add_row(sub_op, 14, 13, 12, 64'h0, 0, 0, 0, 0);
		add_row(addw_op, 15, 14, 13, 64'h0, 0, 0, 0, 0);
		add_row(subw_op, 16, 15, 14, 64'h0, 0, 8, 0, 0);
		// younger independent op passes a waiting one
		add_row(addi_op, 17, 0, 0, 64'h123, 0, 0, 0, 1);
		add_row(add_op, OOO_WAITING_RD, 17, 1, 64'h0, 0, 0, 0, 0);
		add_row(addi_op, OOO_YOUNG_RD, 0, 0, 64'h0, 1, 8, 0, 1);
		// DP waiters on x21 fill the buffer
		add_row(addi_op, 20, 0, 0, 64'h55, 0, 0, 0, 1);
		add_row(add_op, 21, 20, 20, 64'h0, 0, 0, 0, 0);
		add_row(add_op, 22, 21, 0, 64'h0, 0, 0, 0, 0);
		add_row(sub_op, 23, 0, 21, 64'h0, 0, 0, 0, 0);
		add_row(addiw_op, 24, 21, 0, 64'h0, 1, 0, 0, 0);
		add_row(addw_op, 25, 21, 21, 64'h0, 0, 8, 0, 0);
		// x0 writers wait on x26 and get flushed
		add_row(lui_op, 26, 0, 0, 64'h0, 1, 0, 0, 1);
		add_row(add_op, 0, 26, 26, 64'h0, 0, 0, 0, 0);
		add_row(addi_op, 0, 26, 0, 64'h1, 0, 2, 1, 0);
		add_row(add_op, 27, 26, 5, 64'h0, 0, 0, 0, 1);
		add_row(auipc_op, 28, 0, 0, 64'h0, 1, 0, 0, 1);
		add_row(subw_op, 29, 27, 28, 64'h0, 0, 0, 0, 0);
	endtask

	task automatic dispatch_row(input int r);
		row_t   t;
		xdata_t pc;
		xdata_t res;
		t = rows[r];
		pc = BASE_PC + 64'(r) * 64'd4;
		while (dispatch_full) @(negedge CLK);
		res = model_result(t.op, pc, t.imm, model_regs[t.rs1], model_regs[t.rs2]);
		if (t.rd != 5'd0) begin
			model_regs[t.rd] = res;
			expected_val[t.rd] = res;
			dispatched[t.rd] = 1'b1;
			lat_check[t.rd] = t.lat_check;
			disp_cycle[t.rd] = cycle_count;
			dispatch_count++;
		end
		dispatch_valid = 1'b1;
		dispatch_op = t.op;
		dispatch_pc = pc;
		dispatch_imm = t.imm;
		dispatch_rd = t.rd;
		dispatch_rs1 = t.rs1;
		dispatch_rs2 = t.rs2;
		@(negedge CLK);
		dispatch_valid = 1'b0;
		if (t.flush_after) begin
			flush = 1'b1;
			@(negedge CLK);
			flush = 1'b0;
		end
		repeat (t.gap) @(negedge CLK);
	endtask

	// write-back monitor
	always @(negedge CLK) begin
		if (rst_n) begin
			if (dispatch_full) saw_full = 1'b1;
			if (wb_valid) begin
				check_value(64'(dispatched[wb_rd]), 64'd1,
					$sformatf("dispatch before the write to x%0d", wb_rd));
				check_value(wb_data, expected_val[wb_rd], $sformatf("wb_data of x%0d", wb_rd));
				if (lat_check[wb_rd]) begin
					check_value(64'(cycle_count - disp_cycle[wb_rd]), 64'd3,
						$sformatf("write-back latency of x%0d", wb_rd));
				end
				written[wb_rd] = 1'b1;
				wb_cycle[wb_rd] = cycle_count;
				wb_count++;
			end
		end
	end

	initial begin
		int budget;
		#1;
		budget = 0;
		for (int i = 0; i < n_rows; i++) begin
			budget += 1 + int'(rows[i].gap);
		end
		budget *= 20;
		repeat (budget) @(posedge CLK);
		$display("timeout after %0d cycles, write-backs are missing", budget);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		rst_n = 1'b0;
		flush = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_op = '0;
		dispatch_pc = '0;
		dispatch_imm = '0;
		dispatch_rd = '0;
		dispatch_rs1 = '0;
		dispatch_rs2 = '0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		build_table();
		repeat (2) @(negedge CLK);
		rst_n = 1'b1;
		// quiet after reset
		repeat (6) begin
			@(negedge CLK);
			check_value(64'(wb_valid), 64'd0, "wb_valid after reset");
			check_value(64'(dispatch_full), 64'd0, "dispatch_full after reset");
		end
		for (int r = 0; r < n_rows; r++) begin
			dispatch_row(r);
		end
		// every dispatched register written at least once
		while ((dispatched & ~written) != '0) @(negedge CLK);
		repeat (10) @(negedge CLK);
		check_value(64'(wb_count), 64'(dispatch_count), "write-back count");
		check_value(64'(saw_full), 64'd1, "dispatch_full with DP waiting entries");
		check_value(64'(dispatch_full), 64'd0, "dispatch_full after drain");
		check_value(64'(wb_cycle[OOO_YOUNG_RD] < wb_cycle[OOO_WAITING_RD]), 64'd1,
			"younger independent write-back first");
		$display("TEST OK");
		$finish;
	end

endmodule

// ==== compile.f ====
source/isa_pkg.sv
source/issue_pkg.sv
source/adder_buffer.sv
source/adder_slot.sv
source/adder_issue.sv
source/adder_exec.sv
source/regfile_wb.sv
source/adder_core.sv
tb/adder_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing
TOP ?= adder_core_tb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
